// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= mult_unit_tb
LINT_TOP  ?= mult_unit_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/mult_unit_tb.sv ====
`timescale 1ns/10ps

module mult_unit_tb;
	import mult_pkg::*;

	localparam int CORNER_ISSUES = 12;
	localparam int RANDOM_ISSUES = 32;
	localparam int OTHER_ISSUES  = 10;   // late ops, pair, latency, squash
	localparam int NUM_ISSUES    = CORNER_ISSUES + RANDOM_ISSUES + OTHER_ISSUES;
	localparam int CYCLE_LIMIT   = NUM_ISSUES * (MULT_STAGES + 8) + 200;
	localparam int NUM_TAGS      = 64;
	localparam tag_t STRAY_TAG   = 6'd63;   // never handed out

	localparam logic [1:0] SB_FREE   = 2'd0;
	localparam logic [1:0] SB_WAIT   = 2'd1;   // issued, operands pending
	localparam logic [1:0] SB_FLIGHT = 2'd2;

	logic  clock;
	logic  arst_n;
	logic  issue;
	tag_t  issue_tag;
	func_t issue_func;
	word_t issue_opa;
	word_t issue_opb;
	logic  issue_ops_valid;
	logic  wake;
	tag_t  wake_tag;
	word_t wake_opa;
	word_t wake_opb;
	logic  squash;
	logic  issue_ready;
	logic  cdb_valid;
	tag_t  cdb_tag;
	word_t cdb_result;

	// scoreboard indexed by tag
	logic [1:0] sb_state  [NUM_TAGS];
	func_t      sb_func   [NUM_TAGS];
	word_t      sb_result [NUM_TAGS];
	int         outstanding;

	logic [31:0] rng_state;
	tag_t        next_tag;
	int          cycle = 0;
	int          issue_cycle;
	int          last_cdb_cycle;
	int          error_count;
	int          check_count;
	int          cdb_count;
	int          test_num;
	int          test_err_start;

	mult_unit_top u_dut (
		.clock           (clock),
		.arst_n          (arst_n),
		.issue           (issue),
		.issue_tag       (issue_tag),
		.issue_func      (issue_func),
		.issue_opa       (issue_opa),
		.issue_opb       (issue_opb),
		.issue_ops_valid (issue_ops_valid),
		.wake            (wake),
		.wake_tag        (wake_tag),
		.wake_opa        (wake_opa),
		.wake_opb        (wake_opb),
		.squash          (squash),
		.issue_ready     (issue_ready),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.cdb_result      (cdb_result)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	always @(posedge clock) begin
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d results never arrived", cycle, outstanding);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t got);
		check_count++;
		assert (got == expected) else begin
			error_count++;
			$display("Fail at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, got);
		end
	endtask

	a_squash_quiet: assert property (@(posedge clock) disable iff (!arst_n)
		squash |-> !cdb_valid)
		else report_error("cdb_valid high while squash is asserted");

	a_reset_idle: assert property (@(posedge clock)
		!arst_n |-> (!cdb_valid && issue_ready))
		else report_error("outputs not idle during reset");

	a_issue_legal: assert property (@(posedge clock) disable iff (!arst_n)
		issue |-> issue_ready)
		else report_error("issue pulsed while issue_ready is low");

	// result bus monitor
	always @(negedge clock) begin
		if (arst_n && cdb_valid) begin
			cdb_count++;
			check_count++;
			last_cdb_cycle = cycle;
			assert (sb_state[cdb_tag] == SB_FLIGHT) else
				report_error($sformatf("tag %0d on the cdb with nothing in flight", cdb_tag));
			if (sb_state[cdb_tag] == SB_FLIGHT) begin
				check_value("cdb_result", sb_result[cdb_tag], cdb_result);
				sb_state[cdb_tag] = SB_FREE;   // a second copy now fails
				outstanding--;
			end
		end
	end

	function automatic word_t next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// corner values now and then
	function automatic word_t pick_operand();
		word_t r;
		r = next_random();
		case (r[31:29])
			3'd0:    return 32'h8000_0000;
			3'd1:    return 32'hFFFF_FFFF;
			3'd2:    return 32'h0000_0000;
			default: return next_random();
		endcase
	endfunction

	function automatic tag_t new_tag();
		tag_t t;
		t = next_tag;
		next_tag = next_tag + 1'b1;
		return t;
	endfunction

	// RV32M products from the ISA definition
	function automatic word_t ref_product(input func_t func, input word_t a, input word_t b);
		logic [63:0] a64;
		logic [63:0] b64;
		logic [63:0] p;
		a64 = (func == FUNC_MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
		b64 = (func == FUNC_MUL || func == FUNC_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
		p = a64 * b64;
		return (func == FUNC_MUL) ? p[31:0] : p[63:32];
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic send_issue(input tag_t tag, input func_t func, input word_t a,
		input word_t b, input logic ops_valid);
		while (!issue_ready) begin
			wait_cycles(1);
		end
		issue           = 1'b1;
		issue_tag       = tag;
		issue_func      = func;
		issue_opa       = a;
		issue_opb       = b;
		issue_ops_valid = ops_valid;
		sb_func[tag]    = func;
		sb_state[tag]   = ops_valid ? SB_FLIGHT : SB_WAIT;
		if (ops_valid) begin
			sb_result[tag] = ref_product(func, a, b);
		end
		outstanding++;
		wait_cycles(1);
		issue           = 1'b0;
		issue_ops_valid = 1'b0;
		issue_cycle     = cycle;   // count of the issue edge
	endtask

	task automatic send_wake(input tag_t tag, input word_t a, input word_t b);
		wake     = 1'b1;
		wake_tag = tag;
		wake_opa = a;
		wake_opb = b;
		if (sb_state[tag] == SB_WAIT) begin
			sb_result[tag] = ref_product(sb_func[tag], a, b);
			sb_state[tag]  = SB_FLIGHT;
		end
		wait_cycles(1);
		wake = 1'b0;
	endtask

	task automatic wait_drain();
		do begin
			wait_cycles(1);
		end while (outstanding != 0);
	endtask

	task automatic start_test();
		test_num++;
		test_err_start = error_count;
	endtask

	task automatic finish_test(input string name);
		$display("test %0d %s finished with %0d errors", test_num, name,
			error_count - test_err_start);
	endtask

	initial begin
		tag_t  t_a;
		tag_t  t_b;
		tag_t  t_c;
		word_t r;
		int    cdb_seen;
		clock           = 1'b0;
		arst_n          = 1'b1;
		issue           = 1'b0;
		issue_tag       = '0;
		issue_func      = FUNC_MUL;
		issue_opa       = '0;
		issue_opb       = '0;
		issue_ops_valid = 1'b0;
		wake            = 1'b0;
		wake_tag        = '0;
		wake_opa        = '0;
		wake_opb        = '0;
		squash          = 1'b0;
		rng_state       = 32'd52414;
		next_tag        = '0;
		outstanding     = 0;
		error_count     = 0;
		check_count     = 0;
		cdb_count       = 0;
		test_num        = 0;
		for (int t = 0; t < NUM_TAGS; t++) begin
			sb_state[t] = SB_FREE;
		end
		#2;
		arst_n = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		arst_n = 1'b1;

		start_test();
		repeat (3) begin
			@(negedge clock);
			check_value("cdb_valid", 1'b0, cdb_valid);
			check_value("issue_ready", 1'b1, issue_ready);
		end
		wait_cycles(1);
		finish_test("reset state");

		start_test();
		for (int f = 0; f < 4; f++) begin
			send_issue(new_tag(), func_t'(f), 32'h8000_0000, 32'h8000_0000, 1'b1);
			send_issue(new_tag(), func_t'(f), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1);
			send_issue(new_tag(), func_t'(f), 32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
		end
		for (int i = 0; i < RANDOM_ISSUES; i++) begin
			r = next_random();
			send_issue(new_tag(), r[31:30], pick_operand(), pick_operand(), 1'b1);
		end
		wait_drain();
		finish_test("arithmetic");

		start_test();
		cdb_seen = cdb_count;
		t_a = new_tag();
		send_issue(t_a, FUNC_MULHSU, next_random(), next_random(), 1'b0);
		wait_cycles(MULT_STAGES + 2);
		send_wake(STRAY_TAG, next_random(), next_random());   // no unit holds it
		wait_cycles(MULT_STAGES + 2);
		assert (cdb_count == cdb_seen) else
			report_error("late-operand result left before its wake");
		t_b = new_tag();
		send_issue(t_b, FUNC_MUL, next_random(), next_random(), 1'b0);
		send_wake(t_b, pick_operand(), pick_operand());
		send_wake(t_a, pick_operand(), pick_operand());
		wait_drain();
		finish_test("late operands");

		start_test();
		send_issue(new_tag(), FUNC_MULH, pick_operand(), pick_operand(), 1'b1);
		send_issue(new_tag(), FUNC_MULHU, pick_operand(), pick_operand(), 1'b1);
		@(negedge clock);
		check_value("issue_ready", 1'b0, issue_ready);   // both units taken
		while (!cdb_valid) begin
			@(negedge clock);
		end
		@(negedge clock);
		check_value("issue_ready", 1'b1, issue_ready);
		wait_drain();
		finish_test("two units in flight");

		start_test();
		send_issue(new_tag(), FUNC_MUL, pick_operand(), pick_operand(), 1'b1);
		wait_drain();
		check_value("cdb_valid latency", MULT_STAGES + 1, last_cdb_cycle - issue_cycle);
		finish_test("fixed latency");

		start_test();
		t_a = new_tag();
		send_issue(t_a, FUNC_MULH, pick_operand(), pick_operand(), 1'b1);
		t_b = new_tag();
		send_issue(t_b, FUNC_MULHSU, next_random(), next_random(), 1'b0);
		wait_cycles(MULT_STAGES);   // t_a result now offered
		squash = 1'b1;
		for (int t = 0; t < NUM_TAGS; t++) begin
			sb_state[t] = SB_FREE;   // anything in flight is gone
		end
		outstanding = 0;
		wait_cycles(2);
		squash = 1'b0;
		@(negedge clock);
		check_value("issue_ready", 1'b1, issue_ready);
		wait_cycles(1);
		send_wake(t_b, pick_operand(), pick_operand());   // stale tag
		wait_cycles(MULT_STAGES + 2);
		t_c = new_tag();
		send_issue(t_c, FUNC_MULH, next_random(), next_random(), 1'b1);
		wait_cycles(1);
		squash = 1'b1;   // t_c caught inside the core pipeline
		sb_state[t_c] = SB_FREE;
		outstanding = 0;
		wait_cycles(1);
		squash = 1'b0;
		send_issue(new_tag(), FUNC_MULHU, pick_operand(), pick_operand(), 1'b1);
		send_issue(new_tag(), FUNC_MUL, pick_operand(), pick_operand(), 1'b1);
		wait_drain();
		finish_test("squash");

		$display("%0d tests, %0d checks, %0d cdb results, %0d errors",
			test_num, check_count, cdb_count, error_count);
		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== common/mult_pkg.sv ====
package mult_pkg;

	// datapath widths
	localparam int XLEN   = 32;
	localparam int EXT_W  = XLEN + 1;         // operand after sign/zero extension
	localparam int PROD_W = 2 * XLEN;         // full product, mod 2^64

	// operand split inside the multiplier
	localparam int HALF_W = XLEN / 2;         // unsigned low slice
	localparam int HI_W   = EXT_W - HALF_W;   // signed high slice
	localparam int PP_W   = HALF_W + 1 + HI_W; // signed cross partial products

	typedef logic [XLEN-1:0] word_t;
	typedef logic [5:0]      tag_t;           // rename tag
	typedef logic [1:0]      func_t;

	// RV32M funct3 low bits
	localparam func_t FUNC_MUL    = 2'd0;
	localparam func_t FUNC_MULH   = 2'd1;
	localparam func_t FUNC_MULHSU = 2'd2;
	localparam func_t FUNC_MULHU  = 2'd3;

	// pipeline depth of mult_core, at least 4
	localparam int MULT_STAGES = 4;

	// word-wide stages after the final sum
	localparam int TAIL_STAGES = MULT_STAGES - 3;

	localparam int NUM_UNITS = 2;

	typedef logic [0:0] unit_t;               // index of a functional unit

	// functional unit state
	typedef enum logic [1:0] {
		FU_IDLE,
		FU_WAIT_OPS,   // instruction held, operands pending
		FU_BUSY,       // product in flight
		FU_DONE        // result offered to the cdb
	} fu_state_t;

endpackage

// ==== filelist.f ====
common/mult_pkg.sv
fu_mult/mult_core.sv
fu_mult/fu_mult.sv
source/unit_scheduler.sv
source/mult_unit_top.sv
bench/mult_unit_tb.sv

// ==== fu_mult/fu_mult.sv ====
`timescale 1ns/10ps

module fu_mult (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            squash,
	input  logic            sel_issue,
	input  mult_pkg::tag_t  issue_tag,
	input  mult_pkg::func_t issue_func,
	input  mult_pkg::word_t issue_opa,
	input  mult_pkg::word_t issue_opb,
	input  logic            issue_ops_valid,
	input  logic            wake,
	input  mult_pkg::tag_t  wake_tag,
	input  mult_pkg::word_t wake_opa,
	input  mult_pkg::word_t wake_opb,
	input  logic            grant,
	output logic            busy,
	output logic            done,
	output mult_pkg::tag_t  done_tag,
	output mult_pkg::word_t done_result
);
	import mult_pkg::*;

	fu_state_t state_q;
	fu_state_t state_d;

	tag_t  tag_q;
	func_t func_q;
	word_t opa_q;
	word_t opb_q;
	word_t result_q;

	logic  take_issue;
	logic  wake_hit;
	logic  launch;
	logic  start_q;     // one-cycle start into the core
	logic  core_valid;
	word_t core_result;

	assign take_issue = (state_q == FU_IDLE) && sel_issue;

	// only a waiting unit with the same tag takes the wake
	assign wake_hit = wake && (state_q == FU_WAIT_OPS) && (wake_tag == tag_q);

	assign launch = (take_issue && issue_ops_valid) || wake_hit;

	always_comb begin
		state_d = state_q;
		case (state_q)
			FU_IDLE: begin
				if (sel_issue) begin
					state_d = issue_ops_valid ? FU_BUSY : FU_WAIT_OPS;
				end
			end
			FU_WAIT_OPS: begin
				if (wake_hit) begin
					state_d = FU_BUSY;
				end
			end
			FU_BUSY: begin
				if (core_valid) begin
					state_d = FU_DONE;
				end
			end
			FU_DONE: begin
				if (grant) begin
					state_d = FU_IDLE;   // result went out on the cdb
				end
			end
			default: begin
				state_d = FU_IDLE;
			end
		endcase
		if (squash) begin
			state_d = FU_IDLE;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= FU_IDLE;
			start_q <= 1'b0;
		end else begin
			state_q <= state_d;
			start_q <= launch && !squash;
		end
	end

	// instruction and operand holding
	always_ff @(posedge clock) begin
		if (take_issue) begin
			tag_q  <= issue_tag;
			func_q <= issue_func;
			opa_q  <= issue_opa;   // junk until the wake if not valid
			opb_q  <= issue_opb;
		end else if (wake_hit) begin
			opa_q <= wake_opa;
			opb_q <= wake_opb;
		end
		if ((state_q == FU_BUSY) && core_valid) begin
			result_q <= core_result;
		end
	end

	mult_core u_core (
		.clock     (clock),
		.arst_n    (arst_n),
		.flush     (squash),
		.start     (start_q),
		.func      (func_q),
		.opa       (opa_q),
		.opb       (opb_q),
		.out_valid (core_valid),
		.result    (core_result)
	);

	assign busy        = (state_q != FU_IDLE);
	assign done        = (state_q == FU_DONE) && !squash;   // no grant while squashing
	assign done_tag    = tag_q;
	assign done_result = result_q;

endmodule

// ==== fu_mult/mult_core.sv ====
`timescale 1ns/10ps

module mult_core (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            flush,
	input  logic            start,
	input  mult_pkg::func_t func,
	input  mult_pkg::word_t opa,
	input  mult_pkg::word_t opb,
	output logic            out_valid,
	output mult_pkg::word_t result
);
	import mult_pkg::*;

	logic              a_signed;
	logic              b_signed;
	logic [EXT_W-1:0]  ext_a;
	logic [EXT_W-1:0]  ext_b;
	logic [HALF_W-1:0] a_lo;
	logic [HALF_W-1:0] b_lo;
	logic [HI_W-1:0]   a_hi;
	logic [HI_W-1:0]   b_hi;

	logic [MULT_STAGES-1:0] vld_q;   // one valid per stage

	// stage 1, partial products
	logic [2*HALF_W-1:0]     pp_ll_q;
	logic signed [PP_W-1:0]  pp_lh_q;
	logic signed [PP_W-1:0]  pp_hl_q;
	logic signed [PP_W-1:0]  pp_hh_q;
	logic                    hi1_q;

	// stage 2, cross terms folded
	logic [2*HALF_W-1:0]     ll2_q;
	logic signed [PP_W:0]    cross_q;
	logic signed [PP_W-1:0]  hh2_q;
	logic                    hi2_q;

	// stage 3, full product
	logic [PROD_W-1:0]       prod_q;
	logic                    hi3_q;

	word_t tail_q [TAIL_STAGES];

	// MULHU unsigned on both sides, MULHSU only on opb
	assign a_signed = (func != FUNC_MULHU);
	assign b_signed = (func == FUNC_MUL) || (func == FUNC_MULH);

	assign ext_a = {a_signed & opa[XLEN-1], opa};
	assign ext_b = {b_signed & opb[XLEN-1], opb};

	assign a_lo = ext_a[HALF_W-1:0];
	assign a_hi = ext_a[EXT_W-1:HALF_W];
	assign b_lo = ext_b[HALF_W-1:0];
	assign b_hi = ext_b[EXT_W-1:HALF_W];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else if (flush) begin
			vld_q <= '0;   // drops everything in flight
		end else begin
			vld_q <= {vld_q[MULT_STAGES-2:0], start};
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			pp_ll_q <= a_lo * b_lo;
			pp_lh_q <= $signed({1'b0, a_lo}) * $signed(b_hi);
			pp_hl_q <= $signed(a_hi) * $signed({1'b0, b_lo});
			pp_hh_q <= $signed(a_hi) * $signed(b_hi);
			hi1_q   <= (func != FUNC_MUL);
		end
		if (vld_q[0]) begin
			ll2_q   <= pp_ll_q;
			cross_q <= pp_lh_q + pp_hl_q;   // both sit at 2^HALF_W
			hh2_q   <= pp_hh_q;
			hi2_q   <= hi1_q;
		end
		if (vld_q[1]) begin
			prod_q <= ({{(PROD_W-PP_W){hh2_q[PP_W-1]}}, hh2_q} << (2 * HALF_W))
				+ ({{(PROD_W-PP_W-1){cross_q[PP_W]}}, cross_q} << HALF_W)
				+ {{(PROD_W-2*HALF_W){1'b0}}, ll2_q};
			hi3_q  <= hi2_q;
		end
		if (vld_q[2]) begin
			tail_q[0] <= hi3_q ? prod_q[PROD_W-1:XLEN] : prod_q[XLEN-1:0];
		end
		for (int k = 1; k < TAIL_STAGES; k++) begin
			if (vld_q[k+2]) begin
				tail_q[k] <= tail_q[k-1];   // extra depth only
			end
		end
	end

	assign out_valid = vld_q[MULT_STAGES-1];
	assign result    = tail_q[TAIL_STAGES-1];

endmodule

// ==== source/mult_unit_top.sv ====
`timescale 1ns/10ps

module mult_unit_top (
	input  logic            clock,
	input  logic            arst_n,
	input  logic            issue,
	input  mult_pkg::tag_t  issue_tag,
	input  mult_pkg::func_t issue_func,
	input  mult_pkg::word_t issue_opa,
	input  mult_pkg::word_t issue_opb,
	input  logic            issue_ops_valid,
	input  logic            wake,
	input  mult_pkg::tag_t  wake_tag,
	input  mult_pkg::word_t wake_opa,
	input  mult_pkg::word_t wake_opb,
	input  logic            squash,
	output logic            issue_ready,
	output logic            cdb_valid,
	output mult_pkg::tag_t  cdb_tag,
	output mult_pkg::word_t cdb_result
);
	import mult_pkg::*;

	logic [NUM_UNITS-1:0] busy;
	logic [NUM_UNITS-1:0] done;
	logic [NUM_UNITS-1:0] sel_issue;
	logic [NUM_UNITS-1:0] grant;
	unit_t                grant_idx;

	tag_t  done_tag    [NUM_UNITS];
	word_t done_result [NUM_UNITS];

	unit_scheduler u_sched (
		.clock       (clock),
		.arst_n      (arst_n),
		.busy        (busy),
		.done        (done),
		.issue       (issue),
		.sel_issue   (sel_issue),
		.grant       (grant),
		.grant_idx   (grant_idx),
		.issue_ready (issue_ready)
	);

	fu_mult u_fu0 (
		.clock           (clock),
		.arst_n          (arst_n),
		.squash          (squash),
		.sel_issue       (sel_issue[0]),
		.issue_tag       (issue_tag),
		.issue_func      (issue_func),
		.issue_opa       (issue_opa),
		.issue_opb       (issue_opb),
		.issue_ops_valid (issue_ops_valid),
		.wake            (wake),
		.wake_tag        (wake_tag),
		.wake_opa        (wake_opa),
		.wake_opb        (wake_opb),
		.grant           (grant[0]),
		.busy            (busy[0]),
		.done            (done[0]),
		.done_tag        (done_tag[0]),
		.done_result     (done_result[0])
	);

	fu_mult u_fu1 (
		.clock           (clock),
		.arst_n          (arst_n),
		.squash          (squash),
		.sel_issue       (sel_issue[1]),
		.issue_tag       (issue_tag),
		.issue_func      (issue_func),
		.issue_opa       (issue_opa),
		.issue_opb       (issue_opb),
		.issue_ops_valid (issue_ops_valid),
		.wake            (wake),
		.wake_tag        (wake_tag),
		.wake_opa        (wake_opa),
		.wake_opb        (wake_opb),
		.grant           (grant[1]),
		.busy            (busy[1]),
		.done            (done[1]),
		.done_tag        (done_tag[1]),
		.done_result     (done_result[1])
	);

	// cdb driven by whichever unit holds the grant
	assign cdb_valid  = |grant;
	assign cdb_tag    = done_tag[grant_idx];
	assign cdb_result = done_result[grant_idx];

endmodule

// ==== source/unit_scheduler.sv ====
`timescale 1ns/10ps

module unit_scheduler (
	input  logic                           clock,
	input  logic                           arst_n,
	input  logic [mult_pkg::NUM_UNITS-1:0] busy,
	input  logic [mult_pkg::NUM_UNITS-1:0] done,
	input  logic                           issue,
	output logic [mult_pkg::NUM_UNITS-1:0] sel_issue,
	output logic [mult_pkg::NUM_UNITS-1:0] grant,
	output mult_pkg::unit_t                grant_idx,
	output logic                           issue_ready
);
	import mult_pkg::*;

	unit_t rr_ptr_q;   // first unit looked at for the next grant

	assign issue_ready = ~&busy;

	// lowest idle unit takes the issue
	always_comb begin : steer
		logic found;
		found     = 1'b0;
		sel_issue = '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (!busy[i] && !found) begin
				sel_issue[i] = issue;
				found        = 1'b1;
			end
		end
	end

	// round-robin over the done units
	always_comb begin : arbitrate
		int   idx;
		logic found;
		found     = 1'b0;
		grant     = '0;
		grant_idx = '0;
		for (int k = 0; k < NUM_UNITS; k++) begin
			idx = (int'(rr_ptr_q) + k) % NUM_UNITS;
			if (done[idx] && !found) begin
				grant[idx] = 1'b1;
				grant_idx  = unit_t'(idx);
				found      = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr_q <= '0;
		end else if (|grant) begin
			// move just past the winner
			rr_ptr_q <= (grant_idx == unit_t'(NUM_UNITS - 1)) ? '0 : grant_idx + 1'b1;
		end
	end

endmodule
